// ==== hdl/counter_lab_pkg.sv ====
`default_nettype none

package counter_lab_pkg;

    // ------------------------------
    // Widths shared across the lab
    // ------------------------------

    // Control word from keys or switches
    localparam int W_CTRL = 8;

    // Segments a to g plus the dot
    localparam int W_SEG = 8;

    // ------------------------------
    // Counter outputs
    // ------------------------------

    typedef struct packed {
        logic [31:0] fast32;     // Every clock
        logic [31:0] slow32;     // Every strobe
        logic [ 2:0] wrap3;      // Every strobe, wraps at 8
        logic [ 2:0] max_up;
        logic [ 2:0] max_down;
        logic [ 4:0] max_en;
        logic [15:0] cascade16;  // Every 16 strobes
    } counter_views_t;

    // View select, bits 5:2 of the control word
    typedef enum logic [3:0] {
        VIEW_FAST     = 4'd0,
        VIEW_FAST_TOP = 4'd1,
        VIEW_SLOW     = 4'd2,
        VIEW_WRAP     = 4'd3,
        VIEW_MAX_UP   = 4'd4,
        VIEW_MAX_DOWN = 4'd5,
        VIEW_MAX_EN   = 4'd6,
        VIEW_CASCADE  = 4'd7
    } view_sel_e;

endpackage

`default_nettype wire

// ==== hdl/strobe_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module strobe_gen
#(
    parameter int STROBE_PERIOD = 4
)
(
    input  logic clk,
    input  logic i_rst,
    output logic o_strobe
);

    localparam int W_DIV = (STROBE_PERIOD > 1) ? $clog2(STROBE_PERIOD) : 1;
    localparam logic [W_DIV - 1:0] LAST = W_DIV'(STROBE_PERIOD - 1);

    logic [W_DIV - 1:0] div_q;

    // Wrap-around divider, stands in for the slow clock
    always_ff @(posedge clk)
    begin
        if (i_rst)
            div_q <= '0;
        else if (div_q == LAST)
            div_q <= '0;
        else
            div_q <= div_q + 1'b1;
    end

    assign o_strobe = (div_q == LAST);

    // ------------------------------
    // Checks
    // ------------------------------

    generate
        if (STROBE_PERIOD > 1)
        begin : g_strobe_check
            // Strobe is a single-cycle pulse
            a_strobe_single : assert property (
                @(posedge clk) disable iff (i_rst) o_strobe |=> !o_strobe
            );
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/counter_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module counter_bank
    import counter_lab_pkg::*;
#(
    parameter int MAX_UP   = 4,
    parameter int MAX_DOWN = 5,
    parameter int MAX_EN   = 8
)
(
    input  logic           clk,
    input  logic           i_rst,
    input  logic           i_clear,
    input  logic           i_strobe,
    input  logic           i_enable,
    output counter_views_t o_views
);

    // Limits sized to their counters
    localparam logic [2:0] LIM_UP   = 3'(MAX_UP);
    localparam logic [2:0] LIM_DOWN = 3'(MAX_DOWN);
    localparam logic [4:0] LIM_EN   = 5'(MAX_EN);

    counter_views_t views_q;

    // Inner counter of the cascade
    logic [3:0] inner_q;

    // ------------------------------
    // Counters
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (i_rst || i_clear)
        begin
            views_q.fast32    <= '0;
            views_q.slow32    <= '0;
            views_q.wrap3     <= '0;
            views_q.max_up    <= '0;
            views_q.max_down  <= LIM_DOWN;
            views_q.max_en    <= '0;
            views_q.cascade16 <= '0;
            inner_q           <= '0;
        end
        else
        begin
            views_q.fast32 <= views_q.fast32 + 32'd1;

            if (i_strobe)
            begin
                views_q.slow32 <= views_q.slow32 + 32'd1;

                // Wraps modulo 8 by its width
                views_q.wrap3 <= views_q.wrap3 + 3'd1;

                if (views_q.max_up == LIM_UP)
                    views_q.max_up <= '0;
                else
                    views_q.max_up <= views_q.max_up + 3'd1;

                if (views_q.max_down == '0)
                    views_q.max_down <= LIM_DOWN;
                else
                    views_q.max_down <= views_q.max_down - 3'd1;

                if (i_enable)
                begin
                    if (views_q.max_en == LIM_EN)
                        views_q.max_en <= '0;
                    else
                        views_q.max_en <= views_q.max_en + 5'd1;
                end

                // Outer step on the same edge the inner one wraps
                inner_q <= inner_q + 4'd1;
                if (inner_q == 4'hf)
                    views_q.cascade16 <= views_q.cascade16 + 16'd1;
            end
        end
    end

    assign o_views = views_q;

    // ------------------------------
    // Checks
    // ------------------------------

    a_max_up_bound : assert property (
        @(posedge clk) disable iff (i_rst) views_q.max_up <= LIM_UP
    );

    a_max_down_bound : assert property (
        @(posedge clk) disable iff (i_rst) views_q.max_down <= LIM_DOWN
    );

    a_max_en_bound : assert property (
        @(posedge clk) disable iff (i_rst) views_q.max_en <= LIM_EN
    );

endmodule

`default_nettype wire

// ==== hdl/counter_view_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module counter_view_mux
    import counter_lab_pkg::*;
#(
    parameter int W_KEY   = 4,
    parameter int W_SW    = 8,
    parameter int W_LED   = 8,
    parameter int W_DIGIT = 8
)
(
    input  logic [W_KEY - 1:0]       i_key,
    input  logic [W_SW - 1:0]        i_sw,
    input  counter_views_t           i_views,
    output logic                     o_clear,
    output logic                     o_enable,
    output logic [W_LED - 1:0]       o_led,
    output logic [W_DIGIT * 4 - 1:0] o_number
);

    localparam int W_NUMBER = W_DIGIT * 4;

    logic [W_CTRL - 1:0] ctrl;
    view_sel_e           view_sel;
    logic [31:0]         shown;

    // Switches win when there are too few keys
    generate
        if (W_KEY < W_CTRL && W_SW >= W_CTRL)
        begin : g_use_switches
            assign ctrl = W_CTRL'(i_sw);
        end
        else
        begin : g_use_keys
            assign ctrl = W_CTRL'(i_key);
        end
    endgenerate

    assign o_clear  = ctrl[0];
    assign o_enable = ctrl[1];
    assign view_sel = view_sel_e'(ctrl[5:2]);

    // ------------------------------
    // View select
    // ------------------------------

    always_comb
    begin
        case (view_sel)
            VIEW_FAST     : shown = i_views.fast32;
            VIEW_FAST_TOP : shown = 32'(i_views.fast32[31:24]);
            VIEW_SLOW     : shown = i_views.slow32;
            VIEW_WRAP     : shown = 32'(i_views.wrap3);
            VIEW_MAX_UP   : shown = 32'(i_views.max_up);
            VIEW_MAX_DOWN : shown = 32'(i_views.max_down);
            VIEW_MAX_EN   : shown = 32'(i_views.max_en);
            VIEW_CASCADE  : shown = 32'(i_views.cascade16);
            default       : shown = '0;
        endcase
    end

    assign o_led    = W_LED'(shown);
    assign o_number = W_NUMBER'(shown);

endmodule

`default_nettype wire

// ==== hdl/seven_segment_display.sv ====
`timescale 1ns/100ps
`default_nettype none

module seven_segment_display
    import counter_lab_pkg::*;
#(
    parameter int W_DIGIT     = 8,
    parameter int SCAN_PERIOD = 8
)
(
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic [W_DIGIT * 4 - 1:0] i_number,
    output logic [W_SEG - 1:0]       o_abcdefgh,
    output logic [W_DIGIT - 1:0]     o_digit
);

    localparam int W_SCAN = (SCAN_PERIOD > 1) ? $clog2(SCAN_PERIOD) : 1;
    localparam logic [W_SCAN - 1:0] SCAN_LAST = W_SCAN'(SCAN_PERIOD - 1);

    logic [W_DIGIT * 4 - 1:0] number_q;
    logic [W_SCAN - 1:0]      scan_q;
    logic [W_DIGIT - 1:0]     digit_q;
    logic [3:0]               nibble;

    // Hex font, a in the MSB, dot in bit 0 left dark
    function automatic logic [W_SEG - 1:0] hex_font(input logic [3:0] value);
        case (value)
            4'h0    : hex_font = 8'b1111_1100;
            4'h1    : hex_font = 8'b0110_0000;
            4'h2    : hex_font = 8'b1101_1010;
            4'h3    : hex_font = 8'b1111_0010;
            4'h4    : hex_font = 8'b0110_0110;
            4'h5    : hex_font = 8'b1011_0110;
            4'h6    : hex_font = 8'b1011_1110;
            4'h7    : hex_font = 8'b1110_0000;
            4'h8    : hex_font = 8'b1111_1110;
            4'h9    : hex_font = 8'b1111_0110;
            4'ha    : hex_font = 8'b1110_1110;
            4'hb    : hex_font = 8'b0011_1110;
            4'hc    : hex_font = 8'b1001_1100;
            4'hd    : hex_font = 8'b0111_1010;
            4'he    : hex_font = 8'b1001_1110;
            default : hex_font = 8'b1000_1110;
        endcase
    endfunction

    // ------------------------------
    // Number and digit scan
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            number_q <= '0;
            scan_q   <= '0;
            digit_q  <= W_DIGIT'(1);
        end
        else
        begin
            number_q <= i_number;

            if (scan_q == SCAN_LAST)
            begin
                scan_q <= '0;
                // Rotate left, top digit back to digit 0
                digit_q <= (digit_q << 1) | (digit_q >> (W_DIGIT - 1));
            end
            else
            begin
                scan_q <= scan_q + 1'b1;
            end
        end
    end

    // Nibble under the lit digit
    always_comb
    begin
        nibble = '0;
        for (int k = 0; k < W_DIGIT; k++)
        begin
            if (digit_q[k])
                nibble = nibble | number_q[k * 4 +: 4];
        end
    end

    assign o_abcdefgh = hex_font(nibble);
    assign o_digit    = digit_q;

    // Exactly one digit lit at any time
    a_digit_onehot : assert property (
        @(posedge clk) disable iff (i_rst) $onehot(o_digit)
    );

endmodule

`default_nettype wire

// ==== hdl/lab_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lab_top
    import counter_lab_pkg::*;
#(
    parameter int W_KEY         = 4,
    parameter int W_SW          = 8,
    parameter int W_LED         = 8,
    parameter int W_DIGIT       = 8,
    parameter int STROBE_PERIOD = 4,
    parameter int MAX_UP        = 4,
    parameter int MAX_DOWN      = 5,
    parameter int MAX_EN        = 8,
    parameter int SCAN_PERIOD   = 8
)
(
    input  logic                 clk,
    input  logic                 i_rst,

    // Keys, switches, LEDs
    input  logic [W_KEY - 1:0]   i_key,
    input  logic [W_SW - 1:0]    i_sw,
    output logic [W_LED - 1:0]   o_led,

    // Multiplexed seven-segment display
    output logic [W_SEG - 1:0]   o_abcdefgh,
    output logic [W_DIGIT - 1:0] o_digit
);

    logic                     strobe;
    logic                     clear;
    logic                     enable;
    counter_views_t           views;
    logic [W_DIGIT * 4 - 1:0] number;

    // ------------------------------
    // Pacing and counters
    // ------------------------------

    strobe_gen #(
        .STROBE_PERIOD (STROBE_PERIOD)
    ) u_strobe_gen (
        .clk      (clk),
        .i_rst    (i_rst),
        .o_strobe (strobe)
    );

    counter_bank #(
        .MAX_UP   (MAX_UP),
        .MAX_DOWN (MAX_DOWN),
        .MAX_EN   (MAX_EN)
    ) u_counter_bank (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_clear  (clear),
        .i_strobe (strobe),
        .i_enable (enable),
        .o_views  (views)
    );

    // ------------------------------
    // Control and outputs
    // ------------------------------

    counter_view_mux #(
        .W_KEY   (W_KEY),
        .W_SW    (W_SW),
        .W_LED   (W_LED),
        .W_DIGIT (W_DIGIT)
    ) u_counter_view_mux (
        .i_key    (i_key),
        .i_sw     (i_sw),
        .i_views  (views),
        .o_clear  (clear),
        .o_enable (enable),
        .o_led    (o_led),
        .o_number (number)
    );

    seven_segment_display #(
        .W_DIGIT     (W_DIGIT),
        .SCAN_PERIOD (SCAN_PERIOD)
    ) u_seven_segment_display (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_number   (number),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit)
    );

endmodule

`default_nettype wire

// ==== sim/lab_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module lab_checker
    import counter_lab_pkg::*;
#(
    parameter int W_SW          = 8,
    parameter int W_LED         = 8,
    parameter int W_DIGIT       = 8,
    parameter int STROBE_PERIOD = 4,
    parameter int MAX_UP        = 4,
    parameter int MAX_DOWN      = 5,
    parameter int MAX_EN        = 8,
    parameter int SCAN_PERIOD   = 8
)
(
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic [W_SW - 1:0]    i_sw,
    input  logic [W_LED - 1:0]   i_led,
    input  logic [W_SEG - 1:0]   i_abcdefgh,
    input  logic [W_DIGIT - 1:0] i_digit,
    output int                   o_errors,
    output int                   o_checks
);

    localparam int W_NUM = W_DIGIT * 4;

    // Segments a to g, a in bit 6
    localparam logic [6:0] FONT [16] = '{
        7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
        7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47
    };

    typedef struct packed {
        logic [31:0]        fast32;
        logic [31:0]        slow32;
        logic [2:0]         wrap3;
        logic [2:0]         max_up;
        logic [2:0]         max_down;
        logic [4:0]         max_en;
        logic [3:0]         inner;
        logic [15:0]        cascade16;
        logic [7:0]         div;
        logic [7:0]         scan;
        logic [7:0]         idx;
        logic [W_NUM - 1:0] number;
    } model_t;

    model_t              model   = '0;
    logic                valid   = 1'b0;
    int                  errors  = 0;
    int                  checks  = 0;
    logic [W_CTRL - 1:0] ctrl;
    logic [W_LED - 1:0]  exp_led;
    logic [W_DIGIT - 1:0] exp_digit;
    logic [W_SEG - 1:0]  exp_seg;

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [31:0] shown_value(input model_t m, input logic [3:0] sel);
        case (sel)
            4'd0    : return m.fast32;
            4'd1    : return {24'd0, m.fast32[31:24]};
            4'd2    : return m.slow32;
            4'd3    : return {29'd0, m.wrap3};
            4'd4    : return {29'd0, m.max_up};
            4'd5    : return {29'd0, m.max_down};
            4'd6    : return {27'd0, m.max_en};
            4'd7    : return {16'd0, m.cascade16};
            default : return 32'd0;
        endcase
    endfunction

    // One rising edge of the whole lab
    function automatic model_t step_model(input model_t m, input logic rst,
                                          input logic [W_CTRL - 1:0] c);
        model_t n;
        logic   strobe;
        n = m;
        if (rst)
        begin
            n = '0;
            n.max_down = 3'(MAX_DOWN);
            return n;
        end
        strobe = (int'(m.div) == STROBE_PERIOD - 1);
        n.div = strobe ? 8'd0 : m.div + 8'd1;
        n.number = W_NUM'(shown_value(m, c[5:2]));
        if (int'(m.scan) == SCAN_PERIOD - 1)
        begin
            n.scan = 8'd0;
            n.idx  = 8'((int'(m.idx) + 1) % W_DIGIT);
        end
        else
        begin
            n.scan = m.scan + 8'd1;
        end
        if (c[0])
        begin
            n.fast32    = '0;
            n.slow32    = '0;
            n.wrap3     = '0;
            n.max_up    = '0;
            n.max_down  = 3'(MAX_DOWN);
            n.max_en    = '0;
            n.inner     = '0;
            n.cascade16 = '0;
        end
        else
        begin
            n.fast32 = m.fast32 + 32'd1;
            if (strobe)
            begin
                n.slow32   = m.slow32 + 32'd1;
                n.wrap3    = 3'((int'(m.wrap3) + 1) % 8);
                n.max_up   = (int'(m.max_up) == MAX_UP) ? 3'd0 : m.max_up + 3'd1;
                n.max_down = (m.max_down == 3'd0) ? 3'(MAX_DOWN) : m.max_down - 3'd1;
                if (c[1])
                    n.max_en = (int'(m.max_en) == MAX_EN) ? 5'd0 : m.max_en + 5'd1;
                n.inner = m.inner + 4'd1;
                if (m.inner == 4'd15)
                    n.cascade16 = m.cascade16 + 16'd1;
            end
        end
        return n;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] got);
        errors = errors + 1;
        $display("MISMATCH %0t: %s expected %h, got %h", $time, what, expected, got);
    endtask

    // ------------------------------
    // Compare at the DUT ports
    // ------------------------------

    always @(posedge clk)
    begin
        ctrl = W_CTRL'(i_sw);
        if (valid)
        begin
            exp_led   = W_LED'(shown_value(model, ctrl[5:2]));
            exp_digit = W_DIGIT'(1) << model.idx;
            exp_seg   = {FONT[model.number[int'(model.idx) * 4 +: 4]], 1'b0};
            checks    = checks + 3;
            if (i_led !== exp_led)
                report_mismatch("o_led", 32'(exp_led), 32'(i_led));
            if (i_digit !== exp_digit)
                report_mismatch("o_digit", 32'(exp_digit), 32'(i_digit));
            if (i_abcdefgh !== exp_seg)
                report_mismatch("o_abcdefgh", 32'(exp_seg), 32'(i_abcdefgh));
        end
        // Model is trusted once the DUT has seen a reset edge
        if (i_rst)
            valid = 1'b1;
        model = step_model(model, i_rst, ctrl);
    end

    assign o_errors = errors;
    assign o_checks = checks;

endmodule

`default_nettype wire

// ==== sim/tb_lab_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lab_top
    import counter_lab_pkg::*;
();

    localparam int W_KEY         = 4;
    localparam int W_SW          = 8;
    localparam int W_LED         = 8;
    localparam int W_DIGIT       = 8;
    localparam int STROBE_PERIOD = 4;
    localparam int MAX_UP        = 4;
    localparam int MAX_DOWN      = 5;
    localparam int MAX_EN        = 8;
    localparam int SCAN_PERIOD   = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int WATCHDOG_NS   = 100_000;
    localparam logic [15:0] LFSR_SEED = 16'd13992;

    logic                 clk;
    logic                 i_rst;
    logic [W_KEY - 1:0]   i_key;
    logic [W_SW - 1:0]    i_sw;
    logic [W_LED - 1:0]   o_led;
    logic [W_SEG - 1:0]   o_abcdefgh;
    logic [W_DIGIT - 1:0] o_digit;
    int                   error_count;
    int                   check_count;
    int                   timeouts;
    int                   tests_run;
    int                   errors_at_start;
    int                   timeouts_at_start;
    logic [15:0]          lfsr_q;

    initial
    begin
        clk = 1'b0;
        forever #(2) clk = ~clk;
    end

    lab_top #(
        .W_KEY (W_KEY), .W_SW (W_SW), .W_LED (W_LED), .W_DIGIT (W_DIGIT),
        .STROBE_PERIOD (STROBE_PERIOD), .MAX_UP (MAX_UP), .MAX_DOWN (MAX_DOWN),
        .MAX_EN (MAX_EN), .SCAN_PERIOD (SCAN_PERIOD)
    ) u_dut (
        .clk (clk), .i_rst (i_rst), .i_key (i_key), .i_sw (i_sw),
        .o_led (o_led), .o_abcdefgh (o_abcdefgh), .o_digit (o_digit)
    );

    lab_checker #(
        .W_SW (W_SW), .W_LED (W_LED), .W_DIGIT (W_DIGIT),
        .STROBE_PERIOD (STROBE_PERIOD), .MAX_UP (MAX_UP), .MAX_DOWN (MAX_DOWN),
        .MAX_EN (MAX_EN), .SCAN_PERIOD (SCAN_PERIOD)
    ) u_checker (
        .clk (clk), .i_rst (i_rst), .i_sw (i_sw), .i_led (o_led),
        .i_abcdefgh (o_abcdefgh), .i_digit (o_digit),
        .o_errors (error_count), .o_checks (check_count)
    );

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < n; b++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
    endtask

    // Keys carry noise only, the switches hold the control word
    task automatic next_cycle();
        logic [31:0] noise;
        @(negedge clk);
        draw_bits(W_KEY, noise);
        i_key = W_KEY'(noise);
    endtask

    task automatic set_ctrl(input logic [3:0] sel, input logic enable, input logic clear);
        i_sw = W_SW'({2'b00, sel, enable, clear});
    endtask

    task automatic apply_reset();
        next_cycle();
        i_rst = 1'b1;
        repeat (RESET_CYCLES) next_cycle();
        i_rst = 1'b0;
    endtask

    task automatic pulse_clear(input logic [3:0] sel);
        next_cycle();
        set_ctrl(sel, 1'b1, 1'b1);
        next_cycle();
        set_ctrl(sel, 1'b1, 1'b0);
    endtask

    // One clear in sixteen cycles on average
    task automatic run_with_clears(input int n, input logic [3:0] sel);
        logic [31:0] bits;
        for (int i = 0; i < n; i++)
        begin
            next_cycle();
            draw_bits(4, bits);
            set_ctrl(sel, 1'b1, bits[3:0] == 4'd0);
        end
    endtask

    task automatic run_random_enable(input int n, input logic [3:0] sel);
        logic [31:0] bits;
        for (int i = 0; i < n; i++)
        begin
            next_cycle();
            draw_bits(1, bits);
            set_ctrl(sel, bits[0], 1'b0);
        end
    endtask

    task automatic wait_for_led(input logic [W_LED - 1:0] value, input int limit,
                                input string what);
        int count;
        count = 0;
        while (o_led !== value && count < limit)
        begin
            next_cycle();
            count++;
        end
        if (o_led !== value)
        begin
            timeouts++;
            $display("Timeout: %s did not show %0d on the LEDs within %0d cycles",
                     what, value, limit);
        end
    endtask

    task automatic wait_for_digit(input int index, input int limit);
        int count;
        count = 0;
        while (o_digit !== (W_DIGIT'(1) << index) && count < limit)
        begin
            next_cycle();
            count++;
        end
        if (o_digit !== (W_DIGIT'(1) << index))
        begin
            timeouts++;
            $display("Timeout: digit %0d was not lit within %0d cycles", index, limit);
        end
    endtask

    // Clear, then watch the view reach one value and step to the next
    task automatic step_view(input logic [3:0] sel, input int first, input int second,
                             input string what);
        pulse_clear(sel);
        wait_for_led(W_LED'(first), 20 * STROBE_PERIOD, what);
        wait_for_led(W_LED'(second), STROBE_PERIOD + 1, what);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("Test %0d %s: %0d mismatches, %0d timeouts", tests_run, name,
                 error_count - errors_at_start, timeouts - timeouts_at_start);
        errors_at_start   = error_count;
        timeouts_at_start = timeouts;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial
    begin
        lfsr_q            = LFSR_SEED;
        i_rst             = 1'b1;
        i_key             = '0;
        i_sw              = '0;
        timeouts          = 0;
        tests_run         = 0;
        errors_at_start   = 0;
        timeouts_at_start = 0;
        apply_reset();

        run_with_clears(300, VIEW_FAST);
        run_with_clears(300, VIEW_FAST_TOP);
        end_test("fast view and clear");

        step_view(VIEW_SLOW, 12, 13, "slow32");
        step_view(VIEW_WRAP, 7, 0, "wrap3");
        step_view(VIEW_MAX_UP, MAX_UP, 0, "max_up");
        step_view(VIEW_MAX_DOWN, 0, MAX_DOWN, "max_down");
        end_test("slow, wrap and bounded");

        pulse_clear(VIEW_MAX_EN);
        run_random_enable(400, VIEW_MAX_EN);
        next_cycle();
        set_ctrl(VIEW_MAX_EN, 1'b1, 1'b0);
        wait_for_led(W_LED'(MAX_EN), (MAX_EN + 2) * STROBE_PERIOD, "max_en");
        wait_for_led('0, STROBE_PERIOD + 1, "max_en");
        end_test("enabled counter");

        // 2000 cycles give 31 outer steps, the 32nd follows shortly
        pulse_clear(VIEW_CASCADE);
        repeat (2000) next_cycle();
        wait_for_led(W_LED'(32), 200, "cascade16");
        end_test("cascade counter");

        set_ctrl(VIEW_FAST, 1'b1, 1'b0);
        apply_reset();
        wait_for_digit(W_DIGIT - 1, SCAN_PERIOD * W_DIGIT + 2);
        wait_for_digit(0, SCAN_PERIOD + 1);
        run_with_clears(200, VIEW_FAST);
        end_test("display scan");

        for (int sel = 8; sel < 16; sel++)
            run_with_clears(40, 4'(sel));
        end_test("unused selects");

        repeat (4) next_cycle();
        $display("Summary: %0d tests, %0d checks, %0d mismatches, %0d timeouts",
                 tests_run, check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count > 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lab_top.f ====
hdl/counter_lab_pkg.sv
hdl/strobe_gen.sv
hdl/counter_bank.sv
hdl/counter_view_mux.sv
hdl/seven_segment_display.sv
hdl/lab_top.sv
sim/lab_checker.sv
sim/tb_lab_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the counter lab testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_lab_top

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" \
    -f lab_top.f \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$LOG_FILE"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
